/* src/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Instructions per fetch packet
// Also the number of ALU lanes, one lane per slot
`define ALU_SLOTS 2

// Architectural integer registers, x0 included
`define ALU_REGS 32

// Data path width
`define ALU_XLEN 32

// Register stages inside one ALU lane
// Operand stage plus result stage
`define ALU_LANE_LATENCY 2

// Register file read ports, rs1 and rs2 for every slot
`define ALU_RD_PORTS (2 * `ALU_SLOTS)

`endif

/* src/alu_pkg.sv */
`include "alu_defines.svh"

package alu_pkg;

    // Data value or raw instruction word
    typedef logic [`ALU_XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [$clog2(`ALU_REGS)-1:0] reg_idx_t;

    // Lane operations, immediate forms share the register-register codes
    typedef enum logic [3:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI
    } alu_op_e;

    // Held packet state
    // FULL keeps both slots, SPLIT keeps only slot 1
    typedef enum logic [1:0] {
        IDLE,
        FULL,
        SPLIT
    } issue_state_e;

    // One decoded instruction
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     uses_rs2;
        word_t    imm;
    } decoded_op_t;

    // Operands handed to a lane
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        reg_idx_t rd;
        word_t    operand_a;
        word_t    operand_b;
    } lane_issue_t;

    // Result on its way to the register file
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

endpackage

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  alu_pkg::word_t      inst,
    output alu_pkg::decoded_op_t decoded
);

    // RV32I major opcodes handled by the cluster
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_pkg::alu_op_e op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op = alu_pkg::OP_NONE;
        case (opcode)
            OPC_OP: begin
                // Base ops need funct7 zero
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = alu_pkg::OP_ADD;
                        3'b001:  op = alu_pkg::OP_SLL;
                        3'b010:  op = alu_pkg::OP_SLT;
                        3'b011:  op = alu_pkg::OP_SLTU;
                        3'b100:  op = alu_pkg::OP_XOR;
                        3'b101:  op = alu_pkg::OP_SRL;
                        3'b110:  op = alu_pkg::OP_OR;
                        default: op = alu_pkg::OP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    // Alternate encodings, only SUB and SRA exist
                    if (funct3 == 3'b000) begin
                        op = alu_pkg::OP_SUB;
                    end else if (funct3 == 3'b101) begin
                        op = alu_pkg::OP_SRA;
                    end
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = alu_pkg::OP_ADD;
                    3'b010: op = alu_pkg::OP_SLT;
                    3'b011: op = alu_pkg::OP_SLTU;
                    3'b100: op = alu_pkg::OP_XOR;
                    3'b110: op = alu_pkg::OP_OR;
                    3'b111: op = alu_pkg::OP_AND;
                    // Shift immediates check the upper bits
                    3'b001: begin
                        if (funct7 == 7'b0000000) begin
                            op = alu_pkg::OP_SLL;
                        end
                    end
                    default: begin
                        if (funct7 == 7'b0000000) begin
                            op = alu_pkg::OP_SRL;
                        end else if (funct7 == 7'b0100000) begin
                            op = alu_pkg::OP_SRA;
                        end
                    end
                endcase
            end
            OPC_LUI: op = alu_pkg::OP_LUI;
            default: op = alu_pkg::OP_NONE;
        endcase
    end

    always_comb begin
        decoded.valid    = (op != alu_pkg::OP_NONE);
        decoded.op       = op;
        decoded.rd       = inst[11:7];
        // LUI has no source, x0 keeps it clear of the scoreboard
        decoded.rs1      = (opcode == OPC_LUI) ? '0 : inst[19:15];
        decoded.rs2      = inst[24:20];
        decoded.uses_rs2 = (opcode == OPC_OP);
        // U immediate for LUI, sign-extended I immediate otherwise
        if (opcode == OPC_LUI) begin
            decoded.imm = {inst[31:12], 12'b0};
        end else begin
            decoded.imm = {{20{inst[31]}}, inst[31:20]};
        end
    end

endmodule

/* src/issue_control.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module issue_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 packet_valid,
    input  alu_pkg::word_t       packet [`ALU_SLOTS],
    output logic                 stall,
    output alu_pkg::reg_idx_t    rs_idx [`ALU_RD_PORTS],
    input  alu_pkg::word_t       rs_data [`ALU_RD_PORTS],
    output alu_pkg::lane_issue_t lane_in [`ALU_SLOTS],
    input  alu_pkg::commit_t     written [`ALU_SLOTS]
);

    alu_pkg::issue_state_e state_q;
    alu_pkg::issue_state_e state_d;
    alu_pkg::decoded_op_t  dec [`ALU_SLOTS];
    alu_pkg::decoded_op_t  held_q [`ALU_SLOTS];
    alu_pkg::decoded_op_t  cur [`ALU_SLOTS];
    logic [`ALU_REGS-1:0]  busy_q;
    logic [`ALU_REGS-1:0]  busy_eff;
    logic [`ALU_REGS-1:0]  clr_mask;
    logic [`ALU_REGS-1:0]  set_mask;
    logic [`ALU_SLOTS-1:0] ready;
    logic [`ALU_SLOTS-1:0] go;
    logic                  accept;
    logic                  slot0_done;
    logic                  all_done;
    logic                  slot1_conflict;

    // Parallel decode of the incoming packet
    for (genvar g = 0; g < `ALU_SLOTS; g++) begin : decoders
        inst_decoder i_inst_decoder (
            .inst    (packet[g]),
            .decoded (dec[g])
        );
    end

    // Source only sees stall while a packet is held
    assign stall  = (state_q != alu_pkg::IDLE);
    assign accept = (state_q == alu_pkg::IDLE) && packet_valid;

    // Slots under consideration this cycle
    always_comb begin
        case (state_q)
            alu_pkg::FULL: begin
                cur[0] = held_q[0];
                cur[1] = held_q[1];
            end
            alu_pkg::SPLIT: begin
                // Slot 0 already gone
                cur[0]       = held_q[0];
                cur[0].valid = 1'b0;
                cur[1]       = held_q[1];
            end
            default: begin
                cur[0]       = dec[0];
                cur[0].valid = dec[0].valid && packet_valid;
                cur[1]       = dec[1];
                cur[1].valid = dec[1].valid && packet_valid;
            end
        endcase
    end

    // Registers on the commit bus this cycle count as free
    // Their values reach the operands through the register file bypass
    always_comb begin
        clr_mask = '0;
        for (int i = 0; i < `ALU_SLOTS; i++) begin
            if (written[i].valid) begin
                clr_mask[written[i].rd] = 1'b1;
            end
        end
        busy_eff = busy_q & ~clr_mask;
    end

    always_comb begin
        // Busy rd also blocks, a second writer would lose its bit on the first commit
        for (int i = 0; i < `ALU_SLOTS; i++) begin
            ready[i] = cur[i].valid && !busy_eff[cur[i].rs1]
                && !(cur[i].uses_rs2 && busy_eff[cur[i].rs2])
                && !busy_eff[cur[i].rd];
        end
        // Slot 1 touching slot 0's destination waits a cycle
        slot1_conflict = (cur[0].rd != '0) && ((cur[1].rs1 == cur[0].rd)
            || (cur[1].uses_rs2 && (cur[1].rs2 == cur[0].rd))
            || (cur[1].rd == cur[0].rd));
        go[0]      = ready[0];
        // Dropped or issued slot 0 both let slot 1 proceed
        slot0_done = !cur[0].valid || go[0];
        go[1]      = ready[1] && slot0_done && !(cur[0].valid && slot1_conflict);
        all_done   = slot0_done && (!cur[1].valid || go[1]);
        if (all_done) begin
            state_d = alu_pkg::IDLE;
        end else if (slot0_done) begin
            state_d = alu_pkg::SPLIT;
        end else begin
            state_d = alu_pkg::FULL;
        end
    end

    // Operand read and lane hand-off
    always_comb begin
        set_mask = '0;
        for (int i = 0; i < `ALU_SLOTS; i++) begin
            rs_idx[2*i]          = cur[i].rs1;
            rs_idx[2*i+1]        = cur[i].rs2;
            lane_in[i].valid     = go[i];
            lane_in[i].op        = cur[i].op;
            lane_in[i].rd        = cur[i].rd;
            lane_in[i].operand_a = rs_data[2*i];
            lane_in[i].operand_b = cur[i].uses_rs2 ? rs_data[2*i+1] : cur[i].imm;
            if (go[i] && (cur[i].rd != '0)) begin
                set_mask[cur[i].rd] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= alu_pkg::IDLE;
            busy_q  <= '0;
        end else begin
            state_q <= state_d;
            // New issue wins over a same-cycle clear
            busy_q  <= (busy_q & ~clr_mask) | set_mask;
        end
    end

    // Held copy of the decoded packet
    always_ff @(posedge clk) begin
        if (accept) begin
            held_q <= dec;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  alu_pkg::reg_idx_t rs_idx [`ALU_RD_PORTS],
    output alu_pkg::word_t    rs_data [`ALU_RD_PORTS],
    input  alu_pkg::commit_t  wr [`ALU_SLOTS]
);

    alu_pkg::word_t regs [`ALU_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `ALU_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later lane overrides on a shared rd
            for (int i = 0; i < `ALU_SLOTS; i++) begin
                if (wr[i].valid && (wr[i].rd != '0)) begin
                    regs[wr[i].rd] <= wr[i].value;
                end
            end
        end
    end

    // Reads with write-through from the commit bus
    always_comb begin
        for (int p = 0; p < `ALU_RD_PORTS; p++) begin
            rs_data[p] = regs[rs_idx[p]];
            for (int i = 0; i < `ALU_SLOTS; i++) begin
                if (wr[i].valid && (wr[i].rd == rs_idx[p])) begin
                    rs_data[p] = wr[i].value;
                end
            end
            // x0 hardwired
            if (rs_idx[p] == '0) begin
                rs_data[p] = '0;
            end
        end
    end

endmodule

/* src/alu_lane.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_lane (
    input  logic                 clk,
    input  logic                 rst_n,
    input  alu_pkg::lane_issue_t lane_in,
    output alu_pkg::commit_t     lane_out
);

    alu_pkg::lane_issue_t stage_q;
    alu_pkg::commit_t     result_d;
    alu_pkg::commit_t     result_q [`ALU_LANE_LATENCY-1];
    logic [$clog2(`ALU_XLEN)-1:0] shamt;

    // Operand stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= '0;
        end else begin
            stage_q <= lane_in;
        end
    end

    // Shift amount from the low bits of operand b
    assign shamt = stage_q.operand_b[$clog2(`ALU_XLEN)-1:0];

    always_comb begin
        result_d.valid = stage_q.valid;
        result_d.rd    = stage_q.rd;
        case (stage_q.op)
            alu_pkg::OP_ADD:  result_d.value = stage_q.operand_a + stage_q.operand_b;
            alu_pkg::OP_SUB:  result_d.value = stage_q.operand_a - stage_q.operand_b;
            alu_pkg::OP_AND:  result_d.value = stage_q.operand_a & stage_q.operand_b;
            alu_pkg::OP_OR:   result_d.value = stage_q.operand_a | stage_q.operand_b;
            alu_pkg::OP_XOR:  result_d.value = stage_q.operand_a ^ stage_q.operand_b;
            alu_pkg::OP_SLL:  result_d.value = stage_q.operand_a << shamt;
            alu_pkg::OP_SRL:  result_d.value = stage_q.operand_a >> shamt;
            // Arithmetic shift keeps the sign
            alu_pkg::OP_SRA:  result_d.value = $signed(stage_q.operand_a) >>> shamt;
            alu_pkg::OP_SLT: begin
                result_d.value = {31'b0, $signed(stage_q.operand_a) < $signed(stage_q.operand_b)};
            end
            alu_pkg::OP_SLTU: result_d.value = {31'b0, stage_q.operand_a < stage_q.operand_b};
            // Upper immediate arrives already shifted
            alu_pkg::OP_LUI:  result_d.value = stage_q.operand_b;
            default:          result_d.value = '0;
        endcase
    end

    // Result stage, deeper lanes extend the chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `ALU_LANE_LATENCY-1; k++) begin
                result_q[k] <= '0;
            end
        end else begin
            result_q[0] <= result_d;
            for (int k = 1; k < `ALU_LANE_LATENCY-1; k++) begin
                result_q[k] <= result_q[k-1];
            end
        end
    end

    assign lane_out = result_q[`ALU_LANE_LATENCY-2];

endmodule

/* src/writeback_merge.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module writeback_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  alu_pkg::commit_t lane_out [`ALU_SLOTS],
    output alu_pkg::commit_t commit [`ALU_SLOTS]
);

    // One register per lane onto the shared result bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ALU_SLOTS; i++) begin
                commit[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ALU_SLOTS; i++) begin
                // x0 results are computed but never committed
                commit[i].valid <= lane_out[i].valid && (lane_out[i].rd != '0);
                commit[i].rd    <= lane_out[i].rd;
                commit[i].value <= lane_out[i].value;
            end
        end
    end

    // Same bus feeds the outside, register file writes and busy clears

endmodule

/* src/alu_cluster.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_cluster (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             packet_valid,
    input  alu_pkg::word_t   packet [`ALU_SLOTS],
    output logic             stall,
    output alu_pkg::commit_t commit [`ALU_SLOTS]
);

    // Register file read ports
    alu_pkg::reg_idx_t    rs_idx [`ALU_RD_PORTS];
    alu_pkg::word_t       rs_data [`ALU_RD_PORTS];
    // Issue to lanes and lane results
    alu_pkg::lane_issue_t lane_in [`ALU_SLOTS];
    alu_pkg::commit_t     lane_out [`ALU_SLOTS];

    issue_control i_issue_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .packet_valid (packet_valid),
        .packet       (packet),
        .stall        (stall),
        .rs_idx       (rs_idx),
        .rs_data      (rs_data),
        .lane_in      (lane_in),
        .written      (commit)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rs_data (rs_data),
        .wr      (commit)
    );

    // Identical lanes, one per slot
    for (genvar g = 0; g < `ALU_SLOTS; g++) begin : lanes
        alu_lane i_alu_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .lane_in  (lane_in[g]),
            .lane_out (lane_out[g])
        );
    end

    writeback_merge i_writeback_merge (
        .clk      (clk),
        .rst_n    (rst_n),
        .lane_out (lane_out),
        .commit   (commit)
    );

endmodule

/* dv/tb_alu_cluster.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module tb_alu_cluster;

    // RV32I opcodes used to build stimulus
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam int NUM_TESTS     = 7;
    localparam int T_RESET       = 0;
    localparam int T_SETUP       = 1;
    localparam int T_OPS         = 2;
    localparam int T_SLOT_DEP    = 3;
    localparam int T_CHAIN       = 4;
    localparam int T_X0          = 5;
    localparam int T_UNSUPPORTED = 6;
    // Quiet cycles after the last expected commit, longer than issue to commit
    localparam int SETTLE_CYCLES = 8;

    // One table row, a packet and the test it belongs to
    typedef struct packed {
        int             test;
        alu_pkg::word_t w0;
        alu_pkg::word_t w1;
    } stim_t;

    logic             clk;
    logic             rst_n;
    logic             packet_valid;
    alu_pkg::word_t   packet [`ALU_SLOTS];
    logic             stall;
    alu_pkg::commit_t commit [`ALU_SLOTS];

    stim_t            stim_q [$];
    alu_pkg::commit_t exp_q [$];
    alu_pkg::word_t   ref_regs [`ALU_REGS];
    string            test_name [NUM_TESTS];
    logic             stim_ready;
    logic             stall_seen;
    int               exp_count;
    int               seen_count;
    int               total_commits;
    int               errors;
    int               errors_at_start;
    int               tests_run;

    alu_cluster i_alu_cluster (
        .clk          (clk),
        .rst_n        (rst_n),
        .packet_valid (packet_valid),
        .packet       (packet),
        .stall        (stall),
        .commit       (commit)
    );

    always #10 clk = ~clk;

    // Instruction encoders
    function automatic alu_pkg::word_t r_type(input logic [6:0] f7, input int rs2,
                                              input int rs1, input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic alu_pkg::word_t i_type(input logic [6:0] opc, input logic [11:0] imm,
                                              input int rs1, input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic alu_pkg::word_t u_type(input logic [19:0] imm, input int rd);
        return {imm, rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [19:0] rand20();
        logic [31:0] r;
        r = $urandom();
        return r[19:0];
    endfunction

    function automatic logic [11:0] rand12();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    function automatic logic [4:0] rand5();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    task automatic add_packet(input int test, input alu_pkg::word_t w0, input alu_pkg::word_t w1);
        stim_t row;
        row.test = test;
        row.w0   = w0;
        row.w1   = w1;
        stim_q.push_back(row);
    endtask

    task automatic build_stim();
        // Random upper halves, then random low parts, plus the sign extremes
        add_packet(T_SETUP, u_type(rand20(), 1), u_type(rand20(), 2));
        add_packet(T_SETUP, u_type(rand20(), 3), u_type(rand20(), 4));
        add_packet(T_SETUP, u_type(rand20(), 5), u_type(rand20(), 6));
        add_packet(T_SETUP, i_type(OPC_IMM, rand12(), 1, 3'b000, 1),
                   i_type(OPC_IMM, rand12(), 2, 3'b000, 2));
        add_packet(T_SETUP, i_type(OPC_IMM, rand12(), 3, 3'b000, 3),
                   i_type(OPC_IMM, rand12(), 4, 3'b000, 4));
        add_packet(T_SETUP, i_type(OPC_IMM, rand12(), 5, 3'b000, 5),
                   i_type(OPC_IMM, rand12(), 6, 3'b000, 6));
        add_packet(T_SETUP, u_type(20'h80000, 7), i_type(OPC_IMM, 12'hfff, 0, 3'b000, 8));
        // Every operation, slots independent
        add_packet(T_OPS, r_type(7'h00, 2, 1, 3'b000, 10), r_type(7'h20, 4, 3, 3'b000, 11));
        add_packet(T_OPS, r_type(7'h00, 6, 5, 3'b111, 12), r_type(7'h00, 7, 1, 3'b110, 13));
        add_packet(T_OPS, r_type(7'h00, 8, 2, 3'b100, 14), r_type(7'h00, 3, 1, 3'b001, 15));
        add_packet(T_OPS, r_type(7'h00, 4, 7, 3'b101, 16), r_type(7'h20, 5, 7, 3'b101, 17));
        add_packet(T_OPS, r_type(7'h00, 1, 7, 3'b010, 18), r_type(7'h00, 1, 7, 3'b011, 19));
        add_packet(T_OPS, r_type(7'h00, 8, 1, 3'b010, 20), r_type(7'h00, 1, 8, 3'b011, 21));
        add_packet(T_OPS, i_type(OPC_IMM, rand12(), 1, 3'b000, 22),
                   i_type(OPC_IMM, rand12(), 2, 3'b111, 23));
        add_packet(T_OPS, i_type(OPC_IMM, rand12(), 3, 3'b110, 24),
                   i_type(OPC_IMM, 12'hfff, 4, 3'b100, 25));
        add_packet(T_OPS, i_type(OPC_IMM, {7'h00, 5'd31}, 5, 3'b001, 26),
                   i_type(OPC_IMM, {7'h00, 5'd31}, 8, 3'b101, 27));
        add_packet(T_OPS, i_type(OPC_IMM, {7'h20, 5'd31}, 7, 3'b101, 28),
                   i_type(OPC_IMM, {7'h20, rand5()}, 6, 3'b101, 29));
        add_packet(T_OPS, i_type(OPC_IMM, 12'hfff, 7, 3'b010, 30),
                   i_type(OPC_IMM, 12'hfff, 1, 3'b011, 31));
        add_packet(T_OPS, i_type(OPC_IMM, 12'h000, 8, 3'b010, 9), u_type(rand20(), 10));
        // Slot 1 reads or rewrites slot 0's rd
        add_packet(T_SLOT_DEP, r_type(7'h00, 2, 1, 3'b000, 12), r_type(7'h20, 3, 12, 3'b000, 13));
        add_packet(T_SLOT_DEP, i_type(OPC_IMM, 12'h007, 5, 3'b000, 14),
                   r_type(7'h00, 6, 14, 3'b100, 14));
        add_packet(T_SLOT_DEP, i_type(OPC_IMM, 12'h055, 1, 3'b110, 15),
                   r_type(7'h00, 3, 2, 3'b000, 15));
        // Each packet reads the previous packet's results
        add_packet(T_CHAIN, r_type(7'h00, 2, 1, 3'b000, 20), r_type(7'h00, 4, 3, 3'b100, 21));
        add_packet(T_CHAIN, r_type(7'h20, 21, 20, 3'b000, 22), r_type(7'h00, 5, 21, 3'b001, 23));
        add_packet(T_CHAIN, r_type(7'h00, 23, 22, 3'b110, 24), r_type(7'h00, 22, 20, 3'b000, 25));
        add_packet(T_CHAIN, i_type(OPC_IMM, 12'hffd, 24, 3'b000, 20),
                   r_type(7'h00, 24, 25, 3'b011, 26));
        // x0 as destination and as source
        add_packet(T_X0, r_type(7'h00, 2, 1, 3'b000, 0), i_type(OPC_IMM, 12'h005, 3, 3'b000, 0));
        add_packet(T_X0, r_type(7'h00, 0, 0, 3'b110, 16), r_type(7'h00, 4, 0, 3'b000, 17));
        add_packet(T_X0, u_type(rand20(), 0), r_type(7'h20, 0, 5, 3'b000, 18));
        // Load, branch, MUL and bad funct7 encodings
        add_packet(T_UNSUPPORTED, i_type(OPC_LOAD, 12'h000, 1, 3'b010, 3),
                   i_type(OPC_BRANCH, 12'h000, 1, 3'b000, 2));
        add_packet(T_UNSUPPORTED, r_type(7'h01, 2, 1, 3'b000, 20),
                   i_type(OPC_IMM, 12'h001, 1, 3'b000, 19));
        add_packet(T_UNSUPPORTED, r_type(7'h20, 2, 1, 3'b001, 21),
                   i_type(OPC_IMM, {7'h20, 5'd3}, 1, 3'b001, 22));
        add_packet(T_UNSUPPORTED, r_type(7'h00, 0, 3, 3'b000, 27),
                   r_type(7'h00, 0, 20, 3'b000, 26));
    endtask

    // Sequential reference, one instruction at a time
    task automatic model_exec(input alu_pkg::word_t inst);
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic [6:0]        f7;
        alu_pkg::reg_idx_t rd;
        alu_pkg::word_t    a;
        alu_pkg::word_t    b;
        alu_pkg::word_t    res;
        alu_pkg::commit_t  c;
        logic              ok;
        opc = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        rd  = inst[11:7];
        a   = ref_regs[inst[19:15]];
        b   = (opc == OPC_OP) ? ref_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        res = '0;
        ok  = 1'b1;
        if (opc == OPC_LUI) begin
            res = {inst[31:12], 12'h000};
        end else if (opc == OPC_OP || opc == OPC_IMM) begin
            case (f3)
                3'b000: res = (opc == OPC_OP && f7[5]) ? a - b : a + b;
                3'b001: res = a << b[4:0];
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: res = (a < b) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: begin
                    if (f7[5]) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'b110: res = a | b;
                default: res = a & b;
            endcase
            // funct7 zero, or 0100000 for SUB and right shifts only
            if (opc == OPC_OP || f3 == 3'b001 || f3 == 3'b101) begin
                ok = (f7 == 7'h00)
                    || (f7 == 7'h20 && (f3 == 3'b101 || (opc == OPC_OP && f3 == 3'b000)));
            end
        end else begin
            ok = 1'b0;
        end
        if (ok && rd != 5'd0) begin
            ref_regs[rd] = res;
            c.valid = 1'b1;
            c.rd    = rd;
            c.value = res;
            exp_q.push_back(c);
            exp_count++;
        end
    endtask

    task automatic check_commit(input alu_pkg::commit_t exp, input alu_pkg::commit_t got);
        if (got.rd !== exp.rd || got.value !== exp.value) begin
            errors++;
            $display("FAIL at %0t: commit x%0d = %08h, expected x%0d = %08h",
                     $time, got.rd, got.value, exp.rd, exp.value);
        end
    endtask

    task automatic check_count(input int exp, input int got);
        if (got != exp) begin
            errors++;
            $display("FAIL at %0t: %0d commits seen, %0d expected", $time, got, exp);
        end
    endtask

    task automatic check_stall(input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: stall seen %0b, expected %0b", $time, got, exp);
        end
    endtask

    // Called at posedge plus 1 ns, returns the same way after acceptance
    task automatic send_packet(input alu_pkg::word_t w0, input alu_pkg::word_t w1);
        packet_valid = 1'b1;
        packet[0]    = w0;
        packet[1]    = w1;
        while (stall) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        packet_valid = 1'b0;
    endtask

    task automatic begin_test();
        exp_count       = 0;
        seen_count      = 0;
        stall_seen      = 1'b0;
        errors_at_start = errors;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int t);
        int new_errors;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_count(exp_count, seen_count);
        if (t == T_RESET) begin
            check_stall(1'b0, stall_seen);
        end else if (t == T_SLOT_DEP) begin
            check_stall(1'b1, stall_seen);
        end
        new_errors = errors - errors_at_start;
        tests_run++;
        $display("test %0d %s: %0d of %0d commits, %0d errors",
                 t, test_name[t], seen_count, exp_count, new_errors);
    endtask

    // Commit bus sampled mid-cycle, lane 0 first
    always @(negedge clk) begin : monitor
        alu_pkg::commit_t expected;
        if (rst_n) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            for (int i = 0; i < `ALU_SLOTS; i++) begin
                if (commit[i].valid) begin
                    seen_count++;
                    total_commits++;
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("ERROR: lane %0d committed x%0d at %0t, but no result was expected",
                                 i, commit[i].rd, $time);
                    end else begin
                        expected = exp_q.pop_front();
                        check_commit(expected, commit[i]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_ready);
        limit = stim_q.size() * 10 + 50;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d clock periods", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        int cur;
        clk           = 1'b0;
        rst_n         = 1'b0;
        packet_valid  = 1'b0;
        stim_ready    = 1'b0;
        stall_seen    = 1'b0;
        exp_count     = 0;
        seen_count    = 0;
        total_commits = 0;
        errors        = 0;
        tests_run     = 0;
        for (int i = 0; i < `ALU_SLOTS; i++) begin
            packet[i] = '0;
        end
        for (int r = 0; r < `ALU_REGS; r++) begin
            ref_regs[r] = '0;
        end
        void'($urandom(32'hb5511ff8));
        test_name = '{"idle after reset", "register setup", "independent ops",
                      "slot 1 dependency", "dependent chain", "x0 handling",
                      "unsupported words"};
        build_stim();
        stim_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Nothing sent, bus must stay quiet
        begin_test();
        finish_test(T_RESET);
        cur = stim_q[0].test;
        begin_test();
        foreach (stim_q[n]) begin
            if (stim_q[n].test != cur) begin
                finish_test(cur);
                cur = stim_q[n].test;
                begin_test();
            end
            model_exec(stim_q[n].w0);
            model_exec(stim_q[n].w1);
            send_packet(stim_q[n].w0, stim_q[n].w1);
        end
        finish_test(cur);
        $display("tests %0d, commits %0d, errors %0d", tests_run, total_commits, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/alu_pkg.sv
src/inst_decoder.sv
src/issue_control.sv
src/reg_file.sv
src/alu_lane.sv
src/writeback_merge.sv
src/alu_cluster.sv
dv/tb_alu_cluster.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_alu_cluster
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_MSG  := PASS: all tests

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
